// ==== dbg_cmd_engine.sv ====
// Debug protocol FSM that parses host commands and sequences memory, hart and UART replies
`timescale 1ns/1ps

module dbg_cmd_engine (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              rx_valid_i,
  input  uart_phy_pkg::uart_byte_t          rx_byte_i,
  input  logic                              tx_ack_i,
  input  logic                              mem_ack_i,
  input  uart_phy_pkg::uart_byte_t          mem_rdata_i,
  input  logic                              exec_ack_i,
  input  logic [uart_dbg_pkg::EXIT_W-1:0]   exec_code_i,
  output logic                              tx_req_o,
  output uart_phy_pkg::uart_byte_t          tx_byte_o,
  output logic                              mem_req_o,
  output uart_dbg_pkg::mem_req_t            mem_o,
  output logic                              exec_req_o,
  output logic [uart_dbg_pkg::ENTRY_W-1:0]  exec_entry_o
);

  import uart_phy_pkg::*;
  import uart_dbg_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE,
    S_ADDR,
    S_LEN,
    S_TX,
    S_TX_WAIT,
    S_WR_RX,
    S_MEM,
    S_MEM_WAIT,
    S_NEXT,
    S_EOT,
    S_EXEC,
    S_EXEC_WAIT,
    S_CODE
  } state_e;

  // ret_q is where the FSM resumes after a transmit handshake
  state_e                 state_q;
  state_e                 ret_q;
  uart_byte_t             cmd_q;
  logic [FIELD_CNT_W-1:0] byte_cnt_q;
  logic [ENTRY_W-1:0]     entry_q;
  logic [LEN_W-1:0]       len_q;
  logic [LEN_W-1:0]       remain_q;
  logic [MEM_ADDR_W-1:0]  addr_q;
  uart_byte_t             wdata_q;
  uart_byte_t             tx_byte_q;
  logic [EXIT_W-1:0]      code_q;
  logic                   is_read;
  logic                   is_write;
  logic                   last_field;

  assign is_read    = (cmd_q == CMD_READ);
  assign is_write   = (cmd_q == CMD_WRITE);
  assign last_field = (byte_cnt_q == FIELD_CNT_W'(FIELD_BYTES - 1));

  //////////////////////////////////////////////////
  // Handshake outputs
  //////////////////////////////////////////////////

  assign tx_req_o     = (state_q == S_TX);
  assign tx_byte_o    = tx_byte_q;
  assign mem_req_o    = (state_q == S_MEM);
  assign mem_o        = '{we: is_write, addr: addr_q, wdata: wdata_q};
  assign exec_req_o   = (state_q == S_EXEC);
  assign exec_entry_o = entry_q;

  //////////////////////////////////////////////////
  // Protocol FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= S_IDLE;
      ret_q      <= S_IDLE;
      cmd_q      <= '0;
      byte_cnt_q <= '0;
      entry_q    <= '0;
      len_q      <= '0;
      remain_q   <= '0;
      addr_q     <= '0;
      wdata_q    <= '0;
      tx_byte_q  <= '0;
      code_q     <= '0;
    end else begin
      unique case (state_q)
        // Anything but a challenge or a command is dropped here
        S_IDLE: begin
          if (rx_valid_i) begin
            if (rx_byte_i == CODE_ACK) begin
              tx_byte_q <= CODE_ACK;
              ret_q     <= S_IDLE;
              state_q   <= S_TX;
            end else if (rx_byte_i inside {CMD_READ, CMD_WRITE, CMD_EXEC}) begin
              cmd_q      <= rx_byte_i;
              byte_cnt_q <= '0;
              state_q    <= S_ADDR;
            end
          end
        end
        // Little-endian address, shifted in from the top
        S_ADDR: begin
          if (rx_valid_i) begin
            entry_q    <= {rx_byte_i, entry_q[ENTRY_W-1:8]};
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (last_field) begin
              byte_cnt_q <= '0;
              if (is_read || is_write) begin
                state_q <= S_LEN;
              end else begin
                tx_byte_q <= CODE_ACK;
                ret_q     <= S_EXEC;
                state_q   <= S_TX;
              end
            end
          end
        end
        // Upper length bytes are received but not kept
        S_LEN: begin
          if (rx_valid_i) begin
            if (byte_cnt_q < FIELD_CNT_W'(LEN_BYTES)) begin
              len_q <= {rx_byte_i, len_q[LEN_W-1:8]};
            end
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (last_field) begin
              byte_cnt_q <= '0;
              addr_q     <= entry_q[MEM_ADDR_W-1:0];
              remain_q   <= len_q;
              tx_byte_q  <= CODE_ACK;
              state_q    <= S_TX;
              if (len_q == '0) begin
                ret_q <= S_EOT;
              end else if (is_read) begin
                ret_q <= S_MEM;
              end else begin
                ret_q <= S_WR_RX;
              end
            end
          end
        end
        S_TX: begin
          if (tx_ack_i) state_q <= S_TX_WAIT;
        end
        S_TX_WAIT: begin
          if (!tx_ack_i) state_q <= ret_q;
        end
        S_WR_RX: begin
          if (rx_valid_i) begin
            wdata_q <= rx_byte_i;
            state_q <= S_MEM;
          end
        end
        // Read data is only valid while the acknowledge is high
        S_MEM: begin
          if (mem_ack_i) begin
            tx_byte_q <= mem_rdata_i;
            state_q   <= S_MEM_WAIT;
          end
        end
        S_MEM_WAIT: begin
          if (!mem_ack_i) begin
            if (is_read) begin
              ret_q   <= S_NEXT;
              state_q <= S_TX;
            end else begin
              state_q <= S_NEXT;
            end
          end
        end
        // Address wraps at the memory size
        S_NEXT: begin
          addr_q   <= addr_q + 1'b1;
          remain_q <= remain_q - 1'b1;
          if (remain_q == LEN_W'(1)) begin
            state_q <= S_EOT;
          end else begin
            state_q <= is_read ? S_MEM : S_WR_RX;
          end
        end
        S_EOT: begin
          tx_byte_q <= CODE_EOT;
          ret_q     <= S_IDLE;
          state_q   <= S_TX;
        end
        // Hart runs, host bytes are ignored meanwhile
        S_EXEC: begin
          if (exec_ack_i) begin
            code_q  <= exec_code_i;
            state_q <= S_EXEC_WAIT;
          end
        end
        S_EXEC_WAIT: begin
          if (!exec_ack_i) begin
            tx_byte_q  <= CODE_EOC;
            byte_cnt_q <= '0;
            ret_q      <= S_CODE;
            state_q    <= S_TX;
          end
        end
        // Exit code goes out LSB first
        S_CODE: begin
          tx_byte_q  <= code_q[7:0];
          code_q     <= {8'h00, code_q[EXIT_W-1:8]};
          byte_cnt_q <= byte_cnt_q + 1'b1;
          state_q    <= S_TX;
          if (byte_cnt_q == FIELD_CNT_W'(EXIT_BYTES - 1)) begin
            ret_q <= S_IDLE;
          end else begin
            ret_q <= S_CODE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== dbg_mem.sv ====
// Byte-wide debug memory with a registered acknowledge behind a four-phase request port
`timescale 1ns/1ps

module dbg_mem (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     mem_req_i,
  input  uart_dbg_pkg::mem_req_t   mem_i,
  output logic                     mem_ack_o,
  output uart_phy_pkg::uart_byte_t mem_rdata_o
);

  import uart_phy_pkg::*;
  import uart_dbg_pkg::*;

  uart_byte_t mem_q [2**MEM_ADDR_W];
  logic       access;

  // One access per handshake, on the rising request
  assign access = mem_req_i & ~mem_ack_o;

  // Acknowledge follows the request by one cycle in both directions
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_ack_o <= 1'b0;
    end else begin
      mem_ack_o <= mem_req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (mem_i.we) mem_q[mem_i.addr] <= mem_i.wdata;
      mem_rdata_o <= mem_q[mem_i.addr];
    end
  end

endmodule

// ==== filelist.f ====
uart_phy_pkg.sv
uart_dbg_pkg.sv
uart_rx.sv
uart_tx.sv
dbg_mem.sv
dbg_cmd_engine.sv
uart_dbg_top.sv
tb_uart_dbg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --top-module tb_uart_dbg -f filelist.f > "$LOG" 2>&1 &&
  ./obj_dir/Vtb_uart_dbg >> "$LOG" 2>&1 ||
  echo "Simulation build or run ended with an error" >> "$LOG"
cat "$LOG"
grep -q "STATUS: FAIL" "$LOG" && exit 1
grep -q "STATUS: PASS" "$LOG" || exit 1
exit 0

// ==== tb_uart_dbg.sv ====
// Self-checking testbench for the UART debug server, run from the file list with a host UART model
`timescale 1ns/1ps

module tb_uart_dbg;

  import uart_phy_pkg::*;
  import uart_dbg_pkg::*;

  typedef enum logic [2:0] {
    OP_CHALLENGE,
    OP_BAD_CHALLENGE,
    OP_NOISE,
    OP_WRITE,
    OP_READ,
    OP_EXEC
  } op_e;

  // Data byte 0 is sent first, addr doubles as the exec entry
  typedef struct packed {
    op_e                  kind;
    logic [63:0]          addr;
    logic [63:0]          len;
    logic [7:0][7:0]      data;
    logic [EXIT_W-1:0]    code;
  } row_t;

  localparam int unsigned NUM_ROWS    = 13;
  localparam int unsigned REPLY_DEPTH = 256;
  localparam int unsigned FRAME_CLKS  = FRAME_BITS * CLKS_PER_BIT;

  logic               clk = 1'b0;
  logic               rst_n_i;
  logic               uart_rx_i;
  logic               exec_ack_i;
  logic [EXIT_W-1:0]  exec_code_i;
  logic               uart_tx_o;
  logic               exec_req_o;
  logic [ENTRY_W-1:0] exec_entry_o;

  row_t               rows [NUM_ROWS];
  logic [7:0]         model_mem [256];
  uart_byte_t         reply_buf [REPLY_DEPTH];
  int unsigned        wr_cnt = 0;
  int unsigned        rd_cnt = 0;
  int unsigned        exec_cnt = 0;
  logic [ENTRY_W-1:0] exp_entry = '0;
  logic [EXIT_W-1:0]  exp_code = '0;
  integer             seed = 10716;

  uart_dbg_top uart_dbg_top_i (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .exec_ack_i   ( exec_ack_i   ),
    .exec_code_i  ( exec_code_i  ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_req_o   ( exec_req_o   ),
    .exec_entry_o ( exec_entry_o )
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Checking and host UART model
  //////////////////////////////////////////////////

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // Bits change 1 ns after the rising edge
  task automatic send_frame(input uart_byte_t b, input logic bad_parity);
    logic bits [$];
    bits.push_back(1'b0);
    for (int i = 0; i < 8; i++) bits.push_back(b[i]);
    if (PARITY_EN) bits.push_back((^b) ^ bad_parity);
    bits.push_back(1'b1);
    foreach (bits[i]) begin
      @(posedge clk);
      #1;
      uart_rx_i = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Little-endian, all eight bytes go on the line
  task automatic send_field(input logic [63:0] value);
    for (int i = 0; i < FIELD_BYTES; i++) send_frame(value[8*i +: 8], 1'b0);
  endtask

  task automatic expect_byte(input uart_byte_t expected, input string what);
    while (rd_cnt == wr_cnt) @(negedge clk);
    check_value(64'(reply_buf[rd_cnt % REPLY_DEPTH]), 64'(expected), what);
    rd_cnt++;
  endtask

  function automatic row_t make_row(input op_e kind, input logic [63:0] addr,
                                    input logic [63:0] len, input logic [63:0] data,
                                    input logic [EXIT_W-1:0] code);
    row_t row;
    row.kind = kind;
    row.addr = addr;
    row.len  = len;
    row.data = data;
    row.code = code;
    return row;
  endfunction

  task automatic apply_row(input row_t row);
    int unsigned           n;
    logic [MEM_ADDR_W-1:0] a;
    n = 32'(row.len[LEN_W-1:0]);
    a = row.addr[MEM_ADDR_W-1:0];
    case (row.kind)
      OP_CHALLENGE: begin
        send_frame(CODE_ACK, 1'b0);
        expect_byte(CODE_ACK, "challenge reply");
      end
      OP_BAD_CHALLENGE: send_frame(CODE_ACK, 1'b1);
      OP_NOISE: begin
        for (int i = 0; i < n; i++) send_frame(row.data[i], 1'b0);
      end
      OP_WRITE: begin
        send_frame(CMD_WRITE, 1'b0);
        send_field(row.addr);
        send_field(row.len);
        expect_byte(CODE_ACK, "write ACK");
        for (int i = 0; i < n; i++) begin
          send_frame(row.data[i], 1'b0);
          model_mem[a] = row.data[i];
          a = a + 1'b1;
        end
        expect_byte(CODE_EOT, "write EOT");
      end
      OP_READ: begin
        send_frame(CMD_READ, 1'b0);
        send_field(row.addr);
        send_field(row.len);
        expect_byte(CODE_ACK, "read ACK");
        for (int i = 0; i < n; i++) begin
          expect_byte(model_mem[a], "read data");
          a = a + 1'b1;
        end
        expect_byte(CODE_EOT, "read EOT");
      end
      OP_EXEC: begin
        exp_entry = row.addr;
        exp_code  = row.code;
        n         = exec_cnt + 1;
        send_frame(CMD_EXEC, 1'b0);
        send_field(row.addr);
        expect_byte(CODE_ACK, "exec ACK");
        expect_byte(CODE_EOC, "exec EOC");
        for (int i = 0; i < EXIT_BYTES; i++) expect_byte(row.code[8*i +: 8], "exit code");
        check_value(64'(exec_cnt), 64'(n), "hart handshake count");
      end
    endcase
    // No stray reply may follow
    repeat (3 * FRAME_CLKS) @(posedge clk);
    check_value(64'(wr_cnt), 64'(rd_cnt), "reply byte count");
  endtask

  //////////////////////////////////////////////////
  // Reply monitor and hart model
  //////////////////////////////////////////////////

  // Samples the DUT line in the middle of each bit on the falling edge
  initial begin
    uart_byte_t b;
    wait (rst_n_i === 1'b1);
    forever begin
      @(negedge clk);
      if (uart_tx_o === 1'b0) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        check_value(64'(uart_tx_o), 64'(1'b0), "reply start bit");
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          b[i] = uart_tx_o;
        end
        if (PARITY_EN) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          check_value(64'(uart_tx_o), 64'(^b), "reply parity bit");
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value(64'(uart_tx_o), 64'(1'b1), "reply stop bit");
        reply_buf[wr_cnt % REPLY_DEPTH] = b;
        wr_cnt++;
      end
    end
  end

  initial begin
    int delay;
    exec_ack_i  = 1'b0;
    exec_code_i = '0;
    forever begin
      @(negedge clk);
      if (exec_req_o === 1'b1) begin
        check_value(exec_entry_o, exp_entry, "exec entry address");
        delay = $random(seed) & 31;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        exec_code_i = exp_code;
        exec_ack_i  = 1'b1;
        @(negedge clk);
        while (exec_req_o === 1'b1) @(negedge clk);
        @(posedge clk);
        #1;
        exec_ack_i = 1'b0;
        exec_cnt++;
      end
    end
  end

  // Watchdog sized for 40 frames per row
  initial begin
    #(NUM_ROWS * 40 * FRAME_CLKS * 8 + 20000);
    $display("Timeout: the tests did not finish in the expected time");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n_i   = 1'b0;
    uart_rx_i = 1'b1;
    rows[0]  = make_row(OP_CHALLENGE, 64'h0, 64'h0, 64'h0, 32'h0);
    rows[1]  = make_row(OP_WRITE, 64'h20, 64'h5, 64'h0000_003C_FF01_55AA, 32'h0);
    rows[2]  = make_row(OP_READ, 64'h20, 64'h5, 64'h0, 32'h0);
    // High address and length bytes carry junk on purpose
    rows[3]  = make_row(OP_WRITE, 64'h1234_0000_0000_00FE, 64'h00FF_0000_0000_0004,
                        64'h0000_0000_4332_2110, 32'h0);
    rows[4]  = make_row(OP_READ, 64'h0, 64'h1, 64'h0, 32'h0);
    rows[5]  = make_row(OP_READ, 64'h1, 64'h1, 64'h0, 32'h0);
    rows[6]  = make_row(OP_EXEC, 64'h8000_0000_1234_5678, 64'h0, 64'h0, 32'hDEAD_BEEF);
    rows[7]  = make_row(OP_BAD_CHALLENGE, 64'h0, 64'h0, 64'h0, 32'h0);
    rows[8]  = make_row(OP_CHALLENGE, 64'h0, 64'h0, 64'h0, 32'h0);
    rows[9]  = make_row(OP_NOISE, 64'h0, 64'h4, 64'h0000_0000_04A5_5500, 32'h0);
    rows[10] = make_row(OP_WRITE, 64'h40, 64'h3, 64'h0000_0000_007E_C35A, 32'h0);
    rows[11] = make_row(OP_READ, 64'h40, 64'h3, 64'h0, 32'h0);
    rows[12] = make_row(OP_EXEC, 64'h0000_0000_0000_1000, 64'h0, 64'h0, 32'h0000_0102);

    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    check_value(64'(uart_tx_o), 64'(1'b1), "idle line after reset");
    check_value(64'(exec_req_o), 64'(1'b0), "exec request after reset");

    for (int r = 0; r < NUM_ROWS; r++) apply_row(rows[r]);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== uart_dbg_pkg.sv ====
// Debug protocol codes, field widths and the memory request struct used by the debug server
package uart_dbg_pkg;

  //////////////////////////////////////////////////
  // Protocol bytes
  //////////////////////////////////////////////////

  localparam uart_phy_pkg::uart_byte_t CMD_READ  = 8'h11;
  localparam uart_phy_pkg::uart_byte_t CMD_WRITE = 8'h12;
  localparam uart_phy_pkg::uart_byte_t CMD_EXEC  = 8'h13;
  localparam uart_phy_pkg::uart_byte_t CODE_ACK  = 8'h06;
  localparam uart_phy_pkg::uart_byte_t CODE_EOT  = 8'h04;
  localparam uart_phy_pkg::uart_byte_t CODE_EOC  = 8'h14;

  //////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////

  // Only the low address byte reaches the memory
  localparam int unsigned MEM_ADDR_W  = 8;
  localparam int unsigned LEN_W       = 16;
  localparam int unsigned FIELD_BYTES = 8;
  localparam int unsigned ENTRY_W     = 64;
  localparam int unsigned EXIT_W      = 32;

  // Derived byte counts
  localparam int unsigned LEN_BYTES   = LEN_W / 8;
  localparam int unsigned EXIT_BYTES  = EXIT_W / 8;
  localparam int unsigned FIELD_CNT_W = $clog2(FIELD_BYTES);

  // One memory access, held stable for the whole handshake
  typedef struct packed {
    logic                       we;
    logic [MEM_ADDR_W-1:0]      addr;
    uart_phy_pkg::uart_byte_t   wdata;
  } mem_req_t;

endpackage

// ==== uart_dbg_top.sv ====
// UART debug server top level joining receiver, transmitter, command engine and debug memory
`timescale 1ns/1ps

module uart_dbg_top (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              uart_rx_i,
  input  logic                              exec_ack_i,
  input  logic [uart_dbg_pkg::EXIT_W-1:0]   exec_code_i,
  output logic                              uart_tx_o,
  output logic                              exec_req_o,
  output logic [uart_dbg_pkg::ENTRY_W-1:0]  exec_entry_o
);

  import uart_phy_pkg::*;
  import uart_dbg_pkg::*;

  // Receive path
  logic       rx_valid;
  uart_byte_t rx_byte;

  // Transmit handshake
  logic       tx_req;
  logic       tx_ack;
  uart_byte_t tx_byte;

  // Memory handshake
  logic       mem_req;
  logic       mem_ack;
  mem_req_t   mem;
  uart_byte_t mem_rdata;

  uart_rx i_uart_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_tx i_uart_tx (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .tx_req_i  ( tx_req    ),
    .tx_byte_i ( tx_byte   ),
    .tx_ack_o  ( tx_ack    ),
    .tx_o      ( uart_tx_o )
  );

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_valid_i   ( rx_valid     ),
    .rx_byte_i    ( rx_byte      ),
    .tx_ack_i     ( tx_ack       ),
    .mem_ack_i    ( mem_ack      ),
    .mem_rdata_i  ( mem_rdata    ),
    .exec_ack_i   ( exec_ack_i   ),
    .exec_code_i  ( exec_code_i  ),
    .tx_req_o     ( tx_req       ),
    .tx_byte_o    ( tx_byte      ),
    .mem_req_o    ( mem_req      ),
    .mem_o        ( mem          ),
    .exec_req_o   ( exec_req_o   ),
    .exec_entry_o ( exec_entry_o )
  );

  dbg_mem i_dbg_mem (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .mem_req_i   ( mem_req   ),
    .mem_i       ( mem       ),
    .mem_ack_o   ( mem_ack   ),
    .mem_rdata_o ( mem_rdata )
  );

endmodule

// ==== uart_phy_pkg.sv ====
// UART line framing constants and the byte type shared by the receiver, transmitter and engine
package uart_phy_pkg;

  // Oversampling ratio, clock cycles per bit
  localparam int unsigned CLKS_PER_BIT = 8;

  // Even parity bit between data and stop
  localparam bit PARITY_EN = 1'b1;

  localparam int unsigned DATA_BITS = 8;

  // Start, data, optional parity and stop
  localparam int unsigned FRAME_BITS = 2 + DATA_BITS + int'(PARITY_EN);

  // Counter widths for the bit timing
  localparam int unsigned CLK_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int unsigned BIT_IDX_W = $clog2(FRAME_BITS);

  typedef logic [DATA_BITS-1:0] uart_byte_t;

endpackage

// ==== uart_rx.sv ====
// Oversampling UART receiver, pulses a valid strobe for each frame with good parity and stop bit
`timescale 1ns/1ps

module uart_rx (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     rx_i,
  output logic                     rx_valid_o,
  output uart_phy_pkg::uart_byte_t rx_byte_o
);

  import uart_phy_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  rx_state_e            state_q;
  logic [2:0]           sync_q;
  logic [CLK_CNT_W-1:0] clk_cnt_q;
  logic [BIT_IDX_W-1:0] bit_idx_q;
  logic                 parity_ok_q;
  uart_byte_t           data_q;
  logic                 rx_s;
  logic                 rx_fall;
  logic                 bit_tick;

  // Two flops against metastability, third one for edge detection
  assign rx_s     = sync_q[1];
  assign rx_fall  = sync_q[2] & ~sync_q[1];
  assign bit_tick = (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q      <= '1;
      state_q     <= RX_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      parity_ok_q <= 1'b0;
      rx_valid_o  <= 1'b0;
    end else begin
      sync_q     <= {sync_q[1:0], rx_i};
      rx_valid_o <= 1'b0;
      clk_cnt_q  <= clk_cnt_q + 1'b1;
      unique case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (rx_fall) state_q <= RX_START;
        end
        // Recheck the line in the middle of the start bit
        RX_START: begin
          if (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt_q   <= '0;
            bit_idx_q   <= '0;
            parity_ok_q <= 1'b1;
            state_q     <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == BIT_IDX_W'(DATA_BITS - 1)) begin
              state_q <= PARITY_EN ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (bit_tick) begin
            clk_cnt_q   <= '0;
            parity_ok_q <= (rx_s == ^data_q);
            state_q     <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            rx_valid_o <= rx_s & parity_ok_q;
            state_q    <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_tick) data_q <= {rx_s, data_q[DATA_BITS-1:1]};
  end

  assign rx_byte_o = data_q;

endmodule

// ==== uart_tx.sv ====
// UART transmitter that sends one frame per four-phase request and acknowledges after the stop bit
`timescale 1ns/1ps

module uart_tx (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     tx_req_i,
  input  uart_phy_pkg::uart_byte_t tx_byte_i,
  output logic                     tx_ack_o,
  output logic                     tx_o
);

  import uart_phy_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SHIFT,
    TX_ACK
  } tx_state_e;

  tx_state_e            state_q;
  logic [CLK_CNT_W-1:0] clk_cnt_q;
  logic [BIT_IDX_W-1:0] bit_idx_q;
  logic [DATA_BITS+1:0] shift_q;
  logic                 parity_bit;
  logic                 bit_tick;
  logic                 last_bit;

  // Without parity the filler one just extends the stop level
  assign parity_bit = PARITY_EN ? ^tx_byte_i : 1'b1;
  assign bit_tick   = (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1));
  assign last_bit   = (bit_idx_q == BIT_IDX_W'(FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      tx_ack_o  <= 1'b0;
      tx_o      <= 1'b1;
    end else begin
      unique case (state_q)
        TX_IDLE: begin
          if (tx_req_i) begin
            // Start bit goes out right away
            tx_o      <= 1'b0;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            state_q   <= TX_SHIFT;
          end
        end
        TX_SHIFT: begin
          clk_cnt_q <= clk_cnt_q + 1'b1;
          if (bit_tick) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (last_bit) begin
              tx_o     <= 1'b1;
              tx_ack_o <= 1'b1;
              state_q  <= TX_ACK;
            end else begin
              tx_o <= shift_q[0];
            end
          end
        end
        // Hold the acknowledge until the request is withdrawn
        TX_ACK: begin
          if (!tx_req_i) begin
            tx_ack_o <= 1'b0;
            state_q  <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == TX_IDLE && tx_req_i) begin
      shift_q <= {1'b1, parity_bit, tx_byte_i};
    end else if (state_q == TX_SHIFT && bit_tick) begin
      shift_q <= {1'b1, shift_q[DATA_BITS+1:1]};
    end
  end

endmodule
